// ==== testbench/cdb_select_patterns.txt ====
# rst_before(1 = reset first) request(hex) fu_num_0 fu_num_1 fu_grant(hex) cdb_valid_0 cdb_valid_1
# Counter phase is the line index modulo 4, counted from the last reset
0 00000 0 1 00000 0 0
0 00000 0 1 00000 0 0
0 00000 0 1 00000 0 0
0 00000 0 1 00000 0 0
0 00055 0 1 00001 1 0
0 00055 2 1 00004 1 0
0 00055 4 1 00010 1 0
0 00055 6 1 00040 1 0
0 0A000 0 13 02000 0 1
0 0A000 0 15 08000 0 1
0 0A000 0 13 02000 0 1
0 0A000 0 15 08000 0 1
0 21204 17 1 20000 1 0
0 21204 17 1 20000 1 0
0 48408 0 18 40000 0 1
0 48408 0 18 40000 0 1
0 04801 14 1 04000 1 0
0 00102 0 8 00100 0 1
0 10010 4 16 10010 1 1
0 0AA00 11 15 08800 1 1
0 0AA00 9 13 02200 1 1
0 FFFFF 19 18 C0000 1 1
0 FFFFF 17 16 30000 1 1
0 000EA 6 7 000C0 1 1
0 000AA 0 1 00002 0 1
0 00002 0 1 00002 0 1
0 00088 0 7 00080 0 1
0 00088 0 7 00080 0 1
0 00055 0 1 00001 1 0
1 00055 0 1 00001 1 0
0 00055 2 1 00004 1 0
0 0A000 0 13 02000 0 1
0 0A000 0 15 08000 0 1
0 0A000 0 13 02000 0 1
0 00000 0 1 00000 0 0
0 00A00 9 1 00200 1 0

// ==== compile.f ====
source/fu_layout_pkg.sv
source/cdb_select_pkg.sv
source/priority_fixed4.sv
source/priority_rotate4.sv
source/priority_rotate2.sv
source/fu_selector_2.sv
source/result_grant_decoder.sv
source/cdb_select_top.sv
testbench/tb_cdb_select.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cdb_select -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_cdb_select)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// ==== testbench/tb_cdb_select.sv ====
// Run from the project root; each optional extra reset restarts the rotation at phase 0
`timescale 1ns/10ps

module tb_cdb_select;

    import fu_layout_pkg::*;

    localparam int half_period  = 10;
    localparam int drive_delay  = 2;
    localparam int check_delay  = 16;
    localparam int reset_cycles = 4;

    logic    clock = 1'b0;
    logic    rst;
    fu_vec_t fu_result_valid;
    fu_num_t fu_num_0;
    fu_num_t fu_num_1;
    fu_vec_t fu_grant;
    logic    cdb_valid_0;
    logic    cdb_valid_1;

    // One entry per pattern line
    bit      rst_before  [$];
    fu_vec_t req_in      [$];
    fu_num_t exp_num_0   [$];
    fu_num_t exp_num_1   [$];
    fu_vec_t exp_grant   [$];
    bit      exp_valid_0 [$];
    bit      exp_valid_1 [$];

    int error_count     = 0;
    int check_count     = 0;
    int watchdog_cycles = 0;
    bit load_ok         = 1'b0;

    cdb_select_top dut_i (
        .clock           (clock),
        .rst             (rst),
        .fu_result_valid (fu_result_valid),
        .fu_num_0        (fu_num_0),
        .fu_num_1        (fu_num_1),
        .fu_grant        (fu_grant),
        .cdb_valid_0     (cdb_valid_0),
        .cdb_valid_1     (cdb_valid_1)
    );

    always #half_period clock = ~clock;

    task automatic load_patterns();
        int          fd;
        int          fields;
        string       line;
        int          f_rst;
        logic [31:0] f_req;
        int          f_num_0;
        int          f_num_1;
        logic [31:0] f_grant;
        int          f_valid_0;
        int          f_valid_1;
        fd = $fopen("testbench/cdb_select_patterns.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%d %h %d %d %h %d %d", f_rst, f_req,
                                 f_num_0, f_num_1, f_grant, f_valid_0, f_valid_1);
                // Comment and blank lines never parse as a full pattern
                if (line.getc(0) != "#" && fields == 7) begin
                    rst_before.push_back(f_rst != 0);
                    req_in.push_back(fu_vec_t'(f_req));
                    exp_num_0.push_back(fu_num_t'(f_num_0));
                    exp_num_1.push_back(fu_num_t'(f_num_1));
                    exp_grant.push_back(fu_vec_t'(f_grant));
                    exp_valid_0.push_back(f_valid_0 != 0);
                    exp_valid_1.push_back(f_valid_1 != 0);
                end
            end
            $fclose(fd);
            load_ok = (req_in.size() > 0);
        end
    endtask

    // Counter is held at 0 while rst is high
    task automatic apply_reset();
        rst             = 1'b1;
        fu_result_valid = '0;
        repeat (reset_cycles) @(posedge clock);
        #drive_delay;
        rst = 1'b0;
    endtask

    task automatic check_outputs(input int i);
        check_count += 5;
        assert (fu_num_0 === exp_num_0[i]) else begin
            error_count++;
            $display("error: %0d ns fu_num_0 expected %0d got %0d at pattern %0d",
                     $time, exp_num_0[i], fu_num_0, i);
        end
        assert (fu_num_1 === exp_num_1[i]) else begin
            error_count++;
            $display("error: %0d ns fu_num_1 expected %0d got %0d at pattern %0d",
                     $time, exp_num_1[i], fu_num_1, i);
        end
        assert (fu_grant === exp_grant[i]) else begin
            error_count++;
            $display("error: %0d ns fu_grant expected %05h got %05h at pattern %0d",
                     $time, exp_grant[i], fu_grant, i);
        end
        assert (cdb_valid_0 === exp_valid_0[i]) else begin
            error_count++;
            $display("error: %0d ns cdb_valid_0 expected %0b got %0b at pattern %0d",
                     $time, exp_valid_0[i], cdb_valid_0, i);
        end
        assert (cdb_valid_1 === exp_valid_1[i]) else begin
            error_count++;
            $display("error: %0d ns cdb_valid_1 expected %0b got %0b at pattern %0d",
                     $time, exp_valid_1[i], cdb_valid_1, i);
        end
    endtask

    initial begin
        int resets;
        rst             = 1'b1;
        fu_result_valid = '0;
        resets          = 0;
        load_patterns();
        if (!load_ok) begin
            $display("Pattern file testbench/cdb_select_patterns.txt is missing or empty");
            $display("Test failed");
            $finish;
        end else begin
            foreach (rst_before[i]) begin
                resets += int'(rst_before[i]);
            end
            watchdog_cycles = req_in.size() + reset_cycles * resets + 10;
            apply_reset();
            for (int i = 0; i < req_in.size(); i++) begin
                if (i > 0) begin
                    @(posedge clock);
                    #drive_delay;
                end
                if (rst_before[i]) begin
                    apply_reset();
                end
                fu_result_valid = req_in[i];
                // Sample shortly before the next rising edge
                #check_delay;
                check_outputs(i);
            end
            $display("Checks run %0d, errors %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles before the run finished", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== source/cdb_select_top.sv ====
// Same-cycle selection from result-valid levels; no back-pressure, losers retry next cycle
`timescale 1ns/10ps

module cdb_select_top (
    input  logic                    clock,
    input  logic                    rst,
    input  fu_layout_pkg::fu_vec_t  fu_result_valid,
    output fu_layout_pkg::fu_num_t  fu_num_0,
    output fu_layout_pkg::fu_num_t  fu_num_1,
    output fu_layout_pkg::fu_vec_t  fu_grant,
    output logic                    cdb_valid_0,
    output logic                    cdb_valid_1
);

    import fu_layout_pkg::*;

    cat_vec_t cat_select_0;
    cat_vec_t cat_select_1;

    fu_selector_2 selector_i (
        .clock           (clock),
        .rst             (rst),
        .fu_result_valid (fu_result_valid),
        .fu_num_0        (fu_num_0),
        .fu_num_1        (fu_num_1),
        .cat_select_0    (cat_select_0),
        .cat_select_1    (cat_select_1)
    );

    result_grant_decoder decoder_i (
        .fu_num_0     (fu_num_0),
        .fu_num_1     (fu_num_1),
        .cat_select_0 (cat_select_0),
        .cat_select_1 (cat_select_1),
        .fu_grant     (fu_grant),
        .cdb_valid_0  (cdb_valid_0),
        .cdb_valid_1  (cdb_valid_1)
    );

endmodule

// ==== source/result_grant_decoder.sv ====
// Combinational only; relies on the two halves being disjoint so grants never overlap
`timescale 1ns/10ps

module result_grant_decoder (
    input  fu_layout_pkg::fu_num_t  fu_num_0,
    input  fu_layout_pkg::fu_num_t  fu_num_1,
    input  fu_layout_pkg::cat_vec_t cat_select_0,
    input  fu_layout_pkg::cat_vec_t cat_select_1,
    output fu_layout_pkg::fu_vec_t  fu_grant,
    output logic                    cdb_valid_0,
    output logic                    cdb_valid_1
);

    import fu_layout_pkg::*;

    // A port broadcasts whenever some category won
    assign cdb_valid_0 = |cat_select_0;
    assign cdb_valid_1 = |cat_select_1;

    always_comb begin
        for (int u = 0; u < fu_size; u++) begin
            fu_grant[u] = (cdb_valid_0 && (fu_num_0 == fu_num_t'(u))) ||
                          (cdb_valid_1 && (fu_num_1 == fu_num_t'(u)));
        end
    end

endmodule

// ==== source/fu_selector_2.sv ====
// Half split is fixed; with no request a port reports its first unit, so qualify with cat_select
`timescale 1ns/10ps

module fu_selector_2 (
    input  logic                     clock,
    input  logic                     rst,
    input  fu_layout_pkg::fu_vec_t   fu_result_valid,
    output fu_layout_pkg::fu_num_t   fu_num_0,
    output fu_layout_pkg::fu_num_t   fu_num_1,
    output fu_layout_pkg::cat_vec_t  cat_select_0,
    output fu_layout_pkg::cat_vec_t  cat_select_1
);

    import fu_layout_pkg::*;
    import cdb_select_pkg::*;

    // Per-half views, index 0 feeds port 0 and index 1 feeds port 1
    half_sel_t half_req   [2];
    half_sel_t half_sel   [2];
    cat_vec_t  cat_valid  [2];
    cat_vec_t  cat_sel    [2];
    fu_num_t   half_num   [2];
    rot_cnt_t  cnt;

    // Rotation phase shared by all pickers
    always_ff @(posedge clock) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + rot_cnt_t'(1);
        end
    end

    for (genvar h = 0; h < 2; h++) begin : g_half

        // Gather this half's requests in selection-bit order
        always_comb begin
            for (int i = 0; i < half_fu_size; i++) begin
                half_req[h][i] = fu_result_valid[half_units[h][i]];
            end
        end

        always_comb begin
            cat_valid[h]           = '0;
            cat_valid[h][cat_alu]  = |half_req[h][alu_offset/2-1:0];
            cat_valid[h][cat_ls]   = |half_req[h][ls_offset/2-1:alu_offset/2];
            cat_valid[h][cat_mult] = |half_req[h][mult_offset/2-1:ls_offset/2];
            cat_valid[h][cat_beq]  = |half_req[h][beq_offset/2-1:mult_offset/2];
        end

        priority_fixed4 cat_pick (
            .req (cat_valid[h]),
            .gnt (cat_sel[h])
        );

        priority_rotate4 alu_pick (
            .cnt (cnt),
            .req (half_req[h][alu_offset/2-1:0]),
            .en  (cat_sel[h][cat_alu]),
            .gnt (half_sel[h][alu_offset/2-1:0])
        );

        priority_rotate2 ls_pick (
            .cnt (cnt[0]),
            .req (half_req[h][ls_offset/2-1:alu_offset/2]),
            .en  (cat_sel[h][cat_ls]),
            .gnt (half_sel[h][ls_offset/2-1:alu_offset/2])
        );

        priority_rotate2 mult_pick (
            .cnt (cnt[0]),
            .req (half_req[h][mult_offset/2-1:ls_offset/2]),
            .en  (cat_sel[h][cat_mult]),
            .gnt (half_sel[h][mult_offset/2-1:ls_offset/2])
        );

        priority_rotate2 beq_pick (
            .cnt (cnt[0]),
            .req (half_req[h][beq_offset/2-1:mult_offset/2]),
            .en  (cat_sel[h][cat_beq]),
            .gnt (half_sel[h][beq_offset/2-1:mult_offset/2])
        );

        // One-hot to unit number, empty selection falls back to entry 0
        always_comb begin
            half_num[h] = half_units[h][0];
            for (int i = 1; i < half_fu_size; i++) begin
                if (half_sel[h][i]) begin
                    half_num[h] = half_units[h][i];
                end
            end
        end

    end

    assign fu_num_0     = half_num[0];
    assign fu_num_1     = half_num[1];
    assign cat_select_0 = cat_sel[0];
    assign cat_select_1 = cat_sel[1];

endmodule

// ==== source/priority_rotate2.sv ====
// Combinational only; grant is zero when disabled or when neither request is set
`timescale 1ns/10ps

module priority_rotate2 (
    input  logic       cnt,
    input  logic [1:0] req,
    input  logic       en,
    output logic [1:0] gnt
);

    always_comb begin
        gnt = '0;
        if (en) begin
            // Preferred side follows cnt, other side takes the slot otherwise
            if (req[cnt]) begin
                gnt[cnt] = 1'b1;
            end else if (req[~cnt]) begin
                gnt[~cnt] = 1'b1;
            end
        end
    end

endmodule

// ==== source/priority_rotate4.sv ====
// Combinational only; fairness depends on cnt stepping every cycle; grant is zero when disabled
`timescale 1ns/10ps

module priority_rotate4 (
    input  cdb_select_pkg::rot_cnt_t cnt,
    input  logic [3:0]               req,
    input  logic                     en,
    output logic [3:0]               gnt
);

    import cdb_select_pkg::*;

    // First request at or after cnt wins with wrap
    always_comb begin
        rot_cnt_t idx;
        gnt = '0;
        idx = cnt;
        if (en) begin
            // Walk backward so the smallest offset from cnt is written last
            for (int i = 3; i >= 0; i--) begin
                idx = cnt + rot_cnt_t'(i);
                if (req[idx]) begin
                    gnt      = '0;
                    gnt[idx] = 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/priority_fixed4.sv ====
// Combinational only; highest category index always wins, so lower ones can starve
`timescale 1ns/10ps

module priority_fixed4 (
    input  fu_layout_pkg::cat_vec_t req,
    output fu_layout_pkg::cat_vec_t gnt
);

    import fu_layout_pkg::*;

    // Branch over multiply over load/store over ALU
    always_comb begin
        gnt = '0;
        if (req[cat_beq]) begin
            gnt[cat_beq] = 1'b1;
        end else if (req[cat_mult]) begin
            gnt[cat_mult] = 1'b1;
        end else if (req[cat_ls]) begin
            gnt[cat_ls] = 1'b1;
        end else if (req[cat_alu]) begin
            gnt[cat_alu] = 1'b1;
        end
    end

endmodule

// ==== source/cdb_select_pkg.sv ====
// Selection bit layout per half is fixed: 4 ALU, 2 load/store, 2 multiply, 2 branch
package cdb_select_pkg;

    // Bits 0-3 ALU, 4-5 load/store, 6-7 multiply, 8-9 branch
    typedef logic [fu_layout_pkg::half_fu_size-1:0] half_sel_t;

    // Free-running rotation phase, wraps every four cycles
    typedef logic [1:0] rot_cnt_t;

endpackage

// ==== source/fu_layout_pkg.sv ====
// Unit numbering is fixed at twenty units in four categories; the half lists must match the board
package fu_layout_pkg;

    localparam int fu_size      = 20;
    localparam int half_fu_size = 10;
    localparam int fu_cat       = 4;

    // End offsets of each category range in unit numbering
    localparam int alu_offset  = 8;
    localparam int ls_offset   = 12;
    localparam int mult_offset = 16;
    localparam int beq_offset  = 20;

    // Category bit positions, lowest priority first
    localparam int cat_alu  = 0;
    localparam int cat_ls   = 1;
    localparam int cat_mult = 2;
    localparam int cat_beq  = 3;

    typedef logic [fu_size-1:0] fu_vec_t;
    typedef logic [4:0]         fu_num_t;
    typedef logic [fu_cat-1:0]  cat_vec_t;

    // Units owned by each broadcast port, in selection-bit order
    localparam fu_num_t half_units [2][half_fu_size] = '{
        '{5'd0, 5'd2, 5'd4, 5'd6, 5'd9, 5'd11, 5'd12, 5'd14, 5'd17, 5'd19},
        '{5'd1, 5'd3, 5'd5, 5'd7, 5'd8, 5'd10, 5'd13, 5'd15, 5'd16, 5'd18}
    };

endpackage
